// ==== list.f ====
logic/mips_ctrl_pkg.sv
logic/cycle_sequencer.sv
logic/instr_decoder.sv
logic/alu_control.sv
logic/mem_strobes.sv
logic/control_top.sv
tests/tb_clock_gen.sv
tests/tb_control_top.sv

// ==== Bender.yml ====
package:
  name: mips_ctrl

sources:
  - logic/mips_ctrl_pkg.sv
  - logic/cycle_sequencer.sv
  - logic/instr_decoder.sv
  - logic/alu_control.sv
  - logic/mem_strobes.sv
  - logic/control_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_control_top.sv

// ==== tests/tb_control_top.sv ====
// control unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_control_top;
    import mips_ctrl_pkg::*;

    localparam int N_TESTS = 300;
    localparam int MAX_CYC = N_TESTS * (4 + 3 * 3 + 4) + 8;  // worst stalls plus margin

    typedef struct packed {
        ctrl_t        ctrl;
        alu_fn_t      fn;
        instr_class_t cls;
        logic [3:0]   be;
        logic         bytewrite;
        logic         halfwrite;
    } expect_t;

    // kept opcodes, then four that are not decoded
    localparam logic [23:0][5:0] OPS = {
        OP_RTYPE, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU, OP_LUI,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_J, OP_JAL, 6'b000001, 6'b000110, 6'b011100, 6'b100010
    };
    // kept functs, then jr, mult and mfhi
    localparam logic [15:0][5:0] FNS = {
        FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU, FN_SLL,
        FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, 6'b001000, 6'b011000, 6'b010000
    };

    logic              clk;
    logic              rst_n;
    logic              waitrequest;
    logic [DATA_W-1:0] readdata;
    logic [1:0]        address_align;
    instr_t            instr;
    ctrl_t             ctrl;
    alu_fn_t           alu_fn;
    mem_strb_t         strb;
    logic              regwrite;
    logic              pcwrite;
    logic              inwrite;
    logic              pctoadd;

    logic [31:0]       rng;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] cur_word;
    logic [1:0]        cur_align;
    logic              retired;
    logic              fetch_done;
    int                stall_left;
    int                first_err;
    int                errors;
    int                checks;
    int                cycles;

    expect_t           want;
    phase_t            exp_phase;
    logic [1:0]        next_code;
    mem_strb_t         exp_strb;
    logic [3:0]        exp_flags;  // regwrite, pcwrite, inwrite, pctoadd
    alu_fn_t           exp_fn;
    logic              in_exec;
    logic              retire;

    tb_clock_gen clk_i (
        .clk (clk)
    );

    control_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .address_align (address_align),
        .instr         (instr),
        .ctrl          (ctrl),
        .alu_fn        (alu_fn),
        .strb          (strb),
        .regwrite      (regwrite),
        .pcwrite       (pcwrite),
        .inwrite       (inwrite),
        .pctoadd       (pctoadd)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected control for one instruction word
    function automatic expect_t ref_decode(input logic [31:0] w, input logic [1:0] align);
        expect_t    e;
        logic [5:0] op;
        logic       known;
        logic       is_imm;
        logic       is_load;
        logic       is_store;
        op    = w[31:26];
        known = 1'b1;
        e     = '0;
        e.be  = 4'b1111;
        e.fn  = ALU_ADD;
        case (w[5:0])
            FN_ADDU: e.fn = ALU_ADD;
            FN_SUBU: e.fn = ALU_SUB;
            FN_AND:  e.fn = ALU_AND;
            FN_OR:   e.fn = ALU_OR;
            FN_XOR:  e.fn = ALU_XOR;
            FN_SLT:  e.fn = ALU_SLT;
            FN_SLTU: e.fn = ALU_SLTU;
            FN_SLL:  e.fn = ALU_SLL;
            FN_SRL:  e.fn = ALU_SRL;
            FN_SRA:  e.fn = ALU_SRA;
            FN_SLLV: e.fn = ALU_SLLV;
            FN_SRLV: e.fn = ALU_SRLV;
            FN_SRAV: e.fn = ALU_SRAV;
            default: known = 1'b0;
        endcase
        known = known && (op == OP_RTYPE);  // valid r-format only
        if (!known) begin
            e.fn = ALU_ADD;
        end else begin
            e.ctrl.alu_op = AOP_FUNCT;
        end
        is_imm   = op inside {OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU, OP_LUI};
        is_load  = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        is_store = op inside {OP_SB, OP_SH, OP_SW};
        e.ctrl.alu_src    = is_imm || is_load || is_store;
        e.ctrl.signed_imm = (op == OP_SLTI);
        e.ctrl.jump       = (op == OP_J) || (op == OP_JAL);
        e.ctrl.branch     = (op == OP_BEQ) || (op == OP_BNE);
        e.ctrl.regdst     = known || is_store;
        e.ctrl.memtoreg   = (op == OP_LW);
        e.ctrl.link       = (op == OP_JAL);
        e.ctrl.loadimmed  = (op == OP_LUI);
        case (op)
            OP_ANDI:  e.ctrl.alu_op = AOP_AND;
            OP_ORI:   e.ctrl.alu_op = AOP_OR;
            OP_XORI:  e.ctrl.alu_op = AOP_XOR;
            OP_SLTI:  e.ctrl.alu_op = AOP_SLT;
            OP_SLTIU: e.ctrl.alu_op = AOP_SLTU;
            OP_BEQ:   e.ctrl.alu_op = AOP_EQ;
            OP_BNE:   e.ctrl.alu_op = AOP_NE;
            OP_LB:    e.ctrl.extend = EXT_BYTE_S;
            OP_LBU:   e.ctrl.extend = EXT_BYTE_U;
            OP_LH:    e.ctrl.extend = EXT_HALF_S;
            OP_LHU:   e.ctrl.extend = EXT_HALF_U;
            OP_SB: begin
                e.be        = 4'b0001 << align;
                e.bytewrite = 1'b1;
                e.halfwrite = 1'b1;
            end
            OP_SH: begin
                e.be        = 4'b0011 << align;
                e.halfwrite = 1'b1;
            end
            default: begin
            end
        endcase
        case (e.ctrl.alu_op)
            AOP_AND:  e.fn = ALU_AND;
            AOP_OR:   e.fn = ALU_OR;
            AOP_XOR:  e.fn = ALU_XOR;
            AOP_SLT:  e.fn = ALU_SLT;
            AOP_SLTU: e.fn = ALU_SLTU;
            AOP_EQ:   e.fn = ALU_SUB;  // equal when the difference is zero
            AOP_NE:   e.fn = ALU_NE;
            default: begin
            end
        endcase
        if (known || is_imm) begin
            e.cls = CLS_REG;
        end else if (is_load) begin
            e.cls = CLS_LOAD;
        end else if (is_store) begin
            e.cls = CLS_STORE;
        end else if (e.ctrl.branch) begin
            e.cls = CLS_BRANCH;
        end else if (e.ctrl.jump) begin
            e.cls = CLS_JUMP;
        end
        return e;
    endfunction

    // memory side and instruction stream
    initial begin
        rst_n         = 1'b0;
        waitrequest   = 1'b0;
        readdata      = '0;
        address_align = 2'd0;
        rng           = 32'hb520;
        cur_word      = '0;
        cur_align     = 2'd0;
        stall_left    = 0;
        errors        = 0;
        checks        = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            rng  = xorshift(rng);
            word = rng;
            rng  = xorshift(rng);
            word[31:26] = (rng[4:0] < 5'd24) ? OPS[rng[4:0]] : OP_RTYPE;
            if (word[31:26] == OP_RTYPE) begin
                word[5:0] = FNS[rng[11:8]];
            end
            cur_word      = word;
            cur_align     = rng[17:16];
            first_err     = errors;
            readdata      <= ~word;  // not valid until the fetch is taken
            address_align <= rng[17:16];
            retired = 1'b0;
            while (!retired) begin
                if (stall_left > 0) begin
                    waitrequest <= 1'b1;
                    stall_left  = stall_left - 1;
                end else begin
                    waitrequest <= 1'b0;
                    rng         = xorshift(rng);
                    stall_left  = rng % 4;  // busy cycles before the next free one
                end
                @(negedge clk);
                retired    = pcwrite;
                fetch_done = strb.memread && pctoadd && !waitrequest;
                @(posedge clk);
                // fetched word is returned in the cycle after acceptance
                readdata <= fetch_done ? word : ~word;
            end
            $display("test %0d word %h: %s", t, word, (errors == first_err) ? "ok" : "mismatch");
        end
        $display("%0d tests, %0d cycles checked, %0d errors", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // phase model and per-cycle comparison
    always @(negedge clk) begin
        want = ref_decode(cur_word, cur_align);
        if (rst_n !== 1'b1) begin
            exp_phase = FETCH;
        end else begin
            checks  = checks + 1;
            in_exec = (exp_phase == EXEC1) || (exp_phase == EXEC2);
            retire  = (exp_phase == EXEC2) && !waitrequest;
            exp_strb            = '0;
            exp_strb.memread    = (exp_phase == FETCH)
                                  || (exp_phase == EXEC1 && want.cls == CLS_LOAD);
            exp_strb.memwrite   = (exp_phase == EXEC2) && (want.cls == CLS_STORE);
            exp_strb.byteenable = 4'b1111;
            exp_fn              = ALU_ADD;
            if (in_exec) begin
                exp_strb.byteenable = want.be;
                exp_strb.bytewrite  = want.bytewrite;
                exp_strb.halfwrite  = want.halfwrite;
                exp_fn              = want.fn;
            end
            exp_flags[3] = retire && (want.cls == CLS_REG || want.cls == CLS_LOAD || want.ctrl.link);
            exp_flags[2] = retire;
            exp_flags[1] = (exp_phase == DECODE);
            exp_flags[0] = (exp_phase == FETCH) || (exp_phase == DECODE);
            assert (strb === exp_strb) else begin
                $display("ERROR %0t: strobes %b, expected %b", $time, strb, exp_strb);
                errors = errors + 1;
            end
            assert ({regwrite, pcwrite, inwrite, pctoadd} === exp_flags) else begin
                $display("ERROR %0t: write flags %b, expected %b", $time,
                         {regwrite, pcwrite, inwrite, pctoadd}, exp_flags);
                errors = errors + 1;
            end
            assert (alu_fn === exp_fn) else begin
                $display("ERROR %0t: alu_fn %0d, expected %0d", $time, alu_fn, exp_fn);
                errors = errors + 1;
            end
            if (in_exec) begin
                assert (instr === cur_word) else begin
                    $display("ERROR %0t: instr %h, expected %h", $time, instr, cur_word);
                    errors = errors + 1;
                end
                assert (ctrl === want.ctrl) else begin
                    $display("ERROR %0t: ctrl %b, expected %b", $time, ctrl, want.ctrl);
                    errors = errors + 1;
                end
            end
            // only fetch, load exec1 and exec2 wait for a free memory
            if (exp_phase == DECODE || (exp_phase == EXEC1 && want.cls != CLS_LOAD)
                    || !waitrequest) begin
                next_code = exp_phase + 2'd1;  // exec2 wraps to fetch
                exp_phase = phase_t'(next_code);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYC);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;  // 8 ns period
        end
    end

endmodule

`default_nettype wire

// ==== logic/control_top.sv ====
// mips control unit top
`timescale 1ns/1ps
`default_nettype none

module control_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             waitrequest,
    input  logic [mips_ctrl_pkg::DATA_W-1:0] readdata,
    input  logic [1:0]                       address_align,
    output mips_ctrl_pkg::instr_t            instr,
    output mips_ctrl_pkg::ctrl_t             ctrl,
    output mips_ctrl_pkg::alu_fn_t           alu_fn,
    output mips_ctrl_pkg::mem_strb_t         strb,
    output logic                             regwrite,
    output logic                             pcwrite,
    output logic                             inwrite,
    output logic                             pctoadd
);
    import mips_ctrl_pkg::*;

    phase_t                phase;
    instr_class_t          cls;
    logic [STORE_SIZE-1:0] size;

    cycle_sequencer seq_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .cls         (cls),
        .phase       (phase),
        .instr       (instr)
    );

    instr_decoder dec_i (
        .instr (instr),
        .ctrl  (ctrl),
        .cls   (cls),
        .size  (size)
    );

    alu_control alu_ctrl_i (
        .phase  (phase),
        .alu_op (ctrl.alu_op),
        .instr  (instr),
        .alu_fn (alu_fn)
    );

    mem_strobes strb_i (
        .phase         (phase),
        .cls           (cls),
        .size          (size),
        .waitrequest   (waitrequest),
        .address_align (address_align),
        .strb          (strb),
        .regwrite      (regwrite),
        .pcwrite       (pcwrite),
        .inwrite       (inwrite),
        .pctoadd       (pctoadd)
    );

endmodule

`default_nettype wire

// ==== logic/mem_strobes.sv ====
// memory and write strobes
`timescale 1ns/1ps
`default_nettype none

module mem_strobes (
    input  mips_ctrl_pkg::phase_t                 phase,
    input  mips_ctrl_pkg::instr_class_t           cls,
    input  logic [mips_ctrl_pkg::STORE_SIZE-1:0]  size,
    input  logic                                  waitrequest,
    input  logic [1:0]                            address_align,
    output mips_ctrl_pkg::mem_strb_t              strb,
    output logic                                  regwrite,
    output logic                                  pcwrite,
    output logic                                  inwrite,
    output logic                                  pctoadd
);
    import mips_ctrl_pkg::*;

    logic exec;
    logic store;

    // the instruction register only holds the current word after decode
    assign exec  = (phase == EXEC1) || (phase == EXEC2);
    assign store = exec && (cls == CLS_STORE);

    always_comb begin
        strb.memread    = (phase == FETCH) || ((phase == EXEC1) && (cls == CLS_LOAD));
        strb.memwrite   = (phase == EXEC2) && (cls == CLS_STORE);  // held through stalls
        strb.byteenable = 4'b1111;
        strb.bytewrite  = 1'b0;
        strb.halfwrite  = 1'b0;
        if (store && size == SIZE_BYTE) begin
            strb.byteenable = 4'b0001 << address_align;  // single lane
            strb.bytewrite  = 1'b1;
            strb.halfwrite  = 1'b1;
        end else if (store && size == SIZE_HALF) begin
            strb.byteenable = 4'b0011 << address_align;
            strb.halfwrite  = 1'b1;
        end
    end

    assign pcwrite  = (phase == EXEC2) && !waitrequest;  // marks the end of an instruction
    assign regwrite = pcwrite && (cls == CLS_REG || cls == CLS_LOAD);
    assign inwrite  = (phase == DECODE);
    assign pctoadd  = (phase == FETCH) || (phase == DECODE);

endmodule

`default_nettype wire

// ==== logic/alu_control.sv ====
// alu function resolver
`timescale 1ns/1ps
`default_nettype none

module alu_control (
    input  mips_ctrl_pkg::phase_t  phase,
    input  mips_ctrl_pkg::alu_op_t alu_op,
    input  mips_ctrl_pkg::instr_t  instr,
    output mips_ctrl_pkg::alu_fn_t alu_fn
);
    import mips_ctrl_pkg::*;

    always_comb begin
        if (phase == FETCH || phase == DECODE) begin
            alu_fn = ALU_ADD;  // pc + 4
        end else begin
            case (alu_op)
                AOP_AND:  alu_fn = ALU_AND;
                AOP_OR:   alu_fn = ALU_OR;
                AOP_XOR:  alu_fn = ALU_XOR;
                AOP_SLT:  alu_fn = ALU_SLT;
                AOP_SLTU: alu_fn = ALU_SLTU;
                AOP_EQ:   alu_fn = ALU_SUB;  // zero flag means equal
                AOP_NE:   alu_fn = ALU_NE;
                AOP_FUNCT: begin
                    case (instr.r.funct)
                        FN_SUBU: alu_fn = ALU_SUB;
                        FN_AND:  alu_fn = ALU_AND;
                        FN_OR:   alu_fn = ALU_OR;
                        FN_XOR:  alu_fn = ALU_XOR;
                        FN_SLT:  alu_fn = ALU_SLT;
                        FN_SLTU: alu_fn = ALU_SLTU;
                        FN_SLL:  alu_fn = ALU_SLL;
                        FN_SRL:  alu_fn = ALU_SRL;
                        FN_SRA:  alu_fn = ALU_SRA;
                        FN_SLLV: alu_fn = ALU_SLLV;
                        FN_SRLV: alu_fn = ALU_SRLV;
                        FN_SRAV: alu_fn = ALU_SRAV;
                        default: alu_fn = ALU_ADD;  // addu and undefined functs
                    endcase
                end
                default:  alu_fn = ALU_ADD;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
// instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  mips_ctrl_pkg::instr_t                       instr,
    output mips_ctrl_pkg::ctrl_t                        ctrl,
    output mips_ctrl_pkg::instr_class_t                 cls,
    output logic [mips_ctrl_pkg::STORE_SIZE-1:0]        size
);
    import mips_ctrl_pkg::*;

    logic funct_ok;

    assign funct_ok = instr.r.funct inside {
        FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
        FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV
    };

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = AOP_ADD;
        ctrl.extend = EXT_NONE;
        cls         = CLS_NONE;  // unknown encodings write nothing
        size        = SIZE_WORD;

        case (instr.i.opcode)
            OP_RTYPE: begin
                if (funct_ok) begin
                    ctrl.alu_op = AOP_FUNCT;
                    ctrl.regdst = 1'b1;  // write to rd
                    cls         = CLS_REG;
                end
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU, OP_LUI: begin
                ctrl.alu_src = 1'b1;
                cls          = CLS_REG;
                case (instr.i.opcode)
                    OP_ANDI:  ctrl.alu_op = AOP_AND;
                    OP_ORI:   ctrl.alu_op = AOP_OR;
                    OP_XORI:  ctrl.alu_op = AOP_XOR;
                    OP_SLTI:  ctrl.alu_op = AOP_SLT;
                    OP_SLTIU: ctrl.alu_op = AOP_SLTU;
                    default:  ctrl.alu_op = AOP_ADD;
                endcase
                ctrl.signed_imm = (instr.i.opcode == OP_SLTI);
                ctrl.loadimmed  = (instr.i.opcode == OP_LUI);  // imm16 to upper half
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                ctrl.alu_src = 1'b1;  // base plus offset
                cls          = CLS_LOAD;
                case (instr.i.opcode)
                    OP_LB:   ctrl.extend = EXT_BYTE_S;
                    OP_LBU:  ctrl.extend = EXT_BYTE_U;
                    OP_LH:   ctrl.extend = EXT_HALF_S;
                    OP_LHU:  ctrl.extend = EXT_HALF_U;
                    default: ctrl.memtoreg = 1'b1;  // full word straight to the register
                endcase
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl.alu_src = 1'b1;
                ctrl.regdst  = 1'b1;
                cls          = CLS_STORE;
                case (instr.i.opcode)
                    OP_SB:   size = SIZE_BYTE;
                    OP_SH:   size = SIZE_HALF;
                    default: size = SIZE_WORD;
                endcase
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = AOP_EQ;
                cls         = CLS_BRANCH;
            end
            OP_BNE: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = AOP_NE;
                cls         = CLS_BRANCH;
            end
            OP_J: begin
                ctrl.jump = 1'b1;
                cls       = CLS_JUMP;
            end
            OP_JAL: begin
                ctrl.jump = 1'b1;
                ctrl.link = 1'b1;
                cls       = CLS_REG;  // jal also writes r31
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cycle_sequencer.sv ====
// processor phase sequencer
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             waitrequest,
    input  logic [mips_ctrl_pkg::DATA_W-1:0] readdata,
    input  mips_ctrl_pkg::instr_class_t      cls,
    output mips_ctrl_pkg::phase_t            phase,
    output mips_ctrl_pkg::instr_t            instr
);
    import mips_ctrl_pkg::*;

    phase_t phase_nxt;

    always_comb begin
        phase_nxt = phase;  // hold under back-pressure
        case (phase)
            FETCH: begin
                if (!waitrequest) begin
                    phase_nxt = DECODE;  // fetch accepted
                end
            end
            DECODE: begin
                phase_nxt = EXEC1;  // always a single cycle
            end
            EXEC1: begin
                // only a load waits here for its read to be taken
                if (cls != CLS_LOAD || !waitrequest) begin
                    phase_nxt = EXEC2;
                end
            end
            EXEC2: begin
                if (!waitrequest) begin
                    phase_nxt = FETCH;  // instruction retires
                end
            end
            default: begin
                phase_nxt = FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= FETCH;
        end else begin
            phase <= phase_nxt;
        end
    end

    // fetched word is on readdata during decode
    always_ff @(posedge clk) begin
        if (phase == DECODE) begin
            instr <= readdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mips_ctrl_pkg.sv ====
// mips control unit definitions
`default_nettype none

package mips_ctrl_pkg;

    localparam int DATA_W     = 32;
    localparam int STORE_SIZE = 2;  // width of the store access code

    localparam logic [STORE_SIZE-1:0] SIZE_WORD = 2'd0;
    localparam logic [STORE_SIZE-1:0] SIZE_HALF = 2'd1;
    localparam logic [STORE_SIZE-1:0] SIZE_BYTE = 2'd2;

    // opcodes
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_JAL   = 6'b000011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_SLTIU = 6'b001011;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_LB    = 6'b100000;
    localparam logic [5:0] OP_LH    = 6'b100001;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_LBU   = 6'b100100;
    localparam logic [5:0] OP_LHU   = 6'b100101;
    localparam logic [5:0] OP_SB    = 6'b101000;
    localparam logic [5:0] OP_SH    = 6'b101001;
    localparam logic [5:0] OP_SW    = 6'b101011;

    // r-format functs
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fields_t;

    // one fetched word, three views
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

    typedef enum logic [1:0] {FETCH, DECODE, EXEC1, EXEC2} phase_t;

    typedef enum logic [3:0] {
        AOP_ADD   = 4'b0000,
        AOP_EQ    = 4'b0001,
        AOP_FUNCT = 4'b0010,  // resolved from the funct field
        AOP_AND   = 4'b0100,
        AOP_OR    = 4'b0101,
        AOP_XOR   = 4'b0110,
        AOP_SLT   = 4'b0111,
        AOP_NE    = 4'b1000,
        AOP_SLTU  = 4'b1100
    } alu_op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV, ALU_NE
    } alu_fn_t;

    typedef enum logic [2:0] {
        EXT_NONE   = 3'b000,
        EXT_HALF_U = 3'b100,
        EXT_HALF_S = 3'b101,
        EXT_BYTE_U = 3'b110,
        EXT_BYTE_S = 3'b111
    } extend_t;

    typedef enum logic [2:0] {
        CLS_NONE, CLS_REG, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JUMP
    } instr_class_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;     // second operand from imm16
        logic    signed_imm;
        logic    jump;
        logic    branch;
        logic    regdst;      // destination is rd
        logic    memtoreg;
        logic    link;        // return address to r31
        logic    loadimmed;
        extend_t extend;
    } ctrl_t;

    typedef struct packed {
        logic       memread;
        logic       memwrite;
        logic [3:0] byteenable;
        logic       bytewrite;
        logic       halfwrite;
    } mem_strb_t;

endpackage

`default_nettype wire
